// ==== logic/core_pkg.sv ====
// shared widths, data memory size and control encodings for the EX/MEM back end.
// unused encodings of each select decode to a zero value in the datapath.
package core_pkg;

    // datapath widths.
    localparam int XLEN       = 32;
    localparam int ADDR_LEN   = 32;
    localparam int REG_ADDR_W = 5;

    // data memory, word addressed by alu result bits 7:2.
    localparam int DMEM_DEPTH = 64;
    localparam int DMEM_IDX_W = 6;

    // alu function codes, codes 10 to 15 give zero.
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_func_e;

    // operand 1 select.
    typedef enum logic [1:0] {
        OPSEL_RS1 = 2'd0,
        OPSEL_PC  = 2'd1
    } opsel1_e;

    // operand 2 select.
    typedef enum logic [1:0] {
        OPSEL_RS2 = 2'd0,
        OPSEL_IMM = 2'd1
    } opsel2_e;

    // writeback source, code 3 gives zero.
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wbsel_e;

endpackage

// ==== logic/alu.sv ====
// purely combinational RV32 integer alu, register-register functions only.
// shifts take the low 5 bits of operand 2.
`timescale 1ns/1ps

module alu import core_pkg::*; (
    input  logic [XLEN-1:0] alu_op1_i,
    input  logic [XLEN-1:0] alu_op2_i,
    input  alu_func_e       alu_func_i,
    output logic [XLEN-1:0] alu_out_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt = alu_op2_i[4:0];

    // comparisons kept apart from the case for readability.
    assign lt_signed   = $signed(alu_op1_i) < $signed(alu_op2_i);
    assign lt_unsigned = alu_op1_i < alu_op2_i;

    always_comb begin
        case (alu_func_i)
            ALU_ADD:  alu_out_o = alu_op1_i + alu_op2_i;
            ALU_SUB:  alu_out_o = alu_op1_i - alu_op2_i;
            ALU_SLL:  alu_out_o = alu_op1_i << shamt;
            ALU_SLT:  alu_out_o = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: alu_out_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  alu_out_o = alu_op1_i ^ alu_op2_i;
            ALU_SRL:  alu_out_o = alu_op1_i >> shamt;
            // arithmetic shift keeps the sign bit.
            ALU_SRA:  alu_out_o = XLEN'($signed(alu_op1_i) >>> shamt);
            ALU_OR:   alu_out_o = alu_op1_i | alu_op2_i;
            ALU_AND:  alu_out_o = alu_op1_i & alu_op2_i;
            default:  alu_out_o = '0;
        endcase
    end

endmodule

// ==== logic/execute.sv ====
// execute stage: operand muxes, alu and the EX/MEM register, 1 cycle latency.
// no stall or flush, the register loads every cycle.
`timescale 1ns/1ps

module execute import core_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  opsel1_e               opsel1_i,
    input  opsel2_e               opsel2_i,
    input  alu_func_e             alu_func_i,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    input  logic [XLEN-1:0]       imm_i,
    input  logic [ADDR_LEN-1:0]   pc_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_i,
    input  logic                  rf_w_en_i,
    input  logic                  mem_w_en_i,
    input  wbsel_e                wbsel_i,
    output logic [ADDR_LEN-1:0]   pc_o,
    output logic [XLEN-1:0]       alu_out_o,
    output logic [REG_ADDR_W-1:0] rd_addr_o,
    output logic                  rf_w_en_o,
    output wbsel_e                wbsel_o,
    output logic                  mem_w_en_o,
    output logic [XLEN-1:0]       rs2_data_o
);

    logic [XLEN-1:0] alu_op1;
    logic [XLEN-1:0] alu_op2;
    logic [XLEN-1:0] alu_result;

    // operand 1, rs1 or pc.
    always_comb begin
        case (opsel1_i)
            OPSEL_RS1: alu_op1 = rs1_data_i;
            OPSEL_PC:  alu_op1 = XLEN'(pc_i);
            default:   alu_op1 = '0;
        endcase
    end

    // operand 2, rs2 or immediate.
    always_comb begin
        case (opsel2_i)
            OPSEL_RS2: alu_op2 = rs2_data_i;
            OPSEL_IMM: alu_op2 = imm_i;
            default:   alu_op2 = '0;
        endcase
    end

    alu u_alu (
        .alu_op1_i  (alu_op1),
        .alu_op2_i  (alu_op2),
        .alu_func_i (alu_func_i),
        .alu_out_o  (alu_result)
    );

    // EX/MEM register.
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_o       <= '0;
            alu_out_o  <= '0;
            rd_addr_o  <= '0;
            rf_w_en_o  <= 1'b0;
            wbsel_o    <= WB_ALU;
            mem_w_en_o <= 1'b0;
            rs2_data_o <= '0;
        end else begin
            pc_o       <= pc_i;
            alu_out_o  <= alu_result;
            rd_addr_o  <= rd_addr_i;
            rf_w_en_o  <= rf_w_en_i;
            wbsel_o    <= wbsel_i;
            mem_w_en_o <= mem_w_en_i;
            rs2_data_o <= rs2_data_i;
        end
    end

endmodule

// ==== logic/mem_stage.sv ====
// memory stage: 64-word data memory, word accesses only, alignment is not checked.
// memory contents survive reset, only the MEM/WB register is cleared.
`timescale 1ns/1ps

module mem_stage import core_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [XLEN-1:0]       alu_out_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    input  logic [ADDR_LEN-1:0]   pc_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_i,
    input  logic                  rf_w_en_i,
    input  logic                  mem_w_en_i,
    input  wbsel_e                wbsel_i,
    output logic [XLEN-1:0]       wb_data_o,
    output logic [REG_ADDR_W-1:0] wb_rd_addr_o,
    output logic                  wb_rf_w_en_o
);

    logic [XLEN-1:0]       dmem [DMEM_DEPTH];
    logic [DMEM_IDX_W-1:0] dmem_idx;
    logic [XLEN-1:0]       load_data;
    logic [ADDR_LEN-1:0]   pc_plus4;
    logic [XLEN-1:0]       wb_data_next;

    // byte address bits 1:0 are dropped.
    assign dmem_idx  = alu_out_i[DMEM_IDX_W+1:2];
    assign load_data = dmem[dmem_idx];
    assign pc_plus4  = pc_i + ADDR_LEN'(4);

    // store lands at the end of the MEM cycle.
    always_ff @(posedge clk) begin
        if (mem_w_en_i) begin
            dmem[dmem_idx] <= rs2_data_i;
        end
    end

    // writeback source select.
    always_comb begin
        case (wbsel_i)
            WB_ALU:  wb_data_next = alu_out_i;
            WB_MEM:  wb_data_next = load_data;
            WB_PC4:  wb_data_next = XLEN'(pc_plus4);
            default: wb_data_next = '0;
        endcase
    end

    // MEM/WB register.
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_data_o    <= '0;
            wb_rd_addr_o <= '0;
            wb_rf_w_en_o <= 1'b0;
        end else begin
            wb_data_o    <= wb_data_next;
            wb_rd_addr_o <= rd_addr_i;
            wb_rf_w_en_o <= rf_w_en_i;
        end
    end

endmodule

// ==== logic/ex_mem_top.sv ====
// execute and memory stages back to back, fixed 2 cycle latency.
`timescale 1ns/1ps

module ex_mem_top import core_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  opsel1_e               opsel1_i,
    input  opsel2_e               opsel2_i,
    input  alu_func_e             alu_func_i,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    input  logic [XLEN-1:0]       imm_i,
    input  logic [ADDR_LEN-1:0]   pc_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_i,
    input  logic                  rf_w_en_i,
    input  logic                  mem_w_en_i,
    input  wbsel_e                wbsel_i,
    output logic [XLEN-1:0]       wb_data_o,
    output logic [REG_ADDR_W-1:0] wb_rd_addr_o,
    output logic                  wb_rf_w_en_o
);

    // EX/MEM register contents.
    logic [ADDR_LEN-1:0]   exm_pc;
    logic [XLEN-1:0]       exm_alu_out;
    logic [REG_ADDR_W-1:0] exm_rd_addr;
    logic                  exm_rf_w_en;
    wbsel_e                exm_wbsel;
    logic                  exm_mem_w_en;
    logic [XLEN-1:0]       exm_rs2_data;

    execute u_execute (
        .clk        (clk),
        .reset      (reset),
        .opsel1_i   (opsel1_i),
        .opsel2_i   (opsel2_i),
        .alu_func_i (alu_func_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .imm_i      (imm_i),
        .pc_i       (pc_i),
        .rd_addr_i  (rd_addr_i),
        .rf_w_en_i  (rf_w_en_i),
        .mem_w_en_i (mem_w_en_i),
        .wbsel_i    (wbsel_i),
        .pc_o       (exm_pc),
        .alu_out_o  (exm_alu_out),
        .rd_addr_o  (exm_rd_addr),
        .rf_w_en_o  (exm_rf_w_en),
        .wbsel_o    (exm_wbsel),
        .mem_w_en_o (exm_mem_w_en),
        .rs2_data_o (exm_rs2_data)
    );

    mem_stage u_mem_stage (
        .clk          (clk),
        .reset        (reset),
        .alu_out_i    (exm_alu_out),
        .rs2_data_i   (exm_rs2_data),
        .pc_i         (exm_pc),
        .rd_addr_i    (exm_rd_addr),
        .rf_w_en_i    (exm_rf_w_en),
        .mem_w_en_i   (exm_mem_w_en),
        .wbsel_i      (exm_wbsel),
        .wb_data_o    (wb_data_o),
        .wb_rd_addr_o (wb_rd_addr_o),
        .wb_rf_w_en_o (wb_rf_w_en_o)
    );

endmodule

// ==== dv/tb_clock_gen.sv ====
// clock and reset source, 40 ns period.
// reset is held for 10 rising edges and released on a falling edge.
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (10) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

// ==== dv/ex_mem_assertions.sv ====
// writeback checker for ex_mem_top with a reference model of the alu and data memory.
// loads of words never stored since time zero are not checked.
`timescale 1ns/1ps

module ex_mem_assertions import core_pkg::*; (
    input logic                  clk_i,
    input logic                  reset_i,
    input opsel1_e               opsel1_i,
    input opsel2_e               opsel2_i,
    input alu_func_e             alu_func_i,
    input logic [XLEN-1:0]       rs1_data_i,
    input logic [XLEN-1:0]       rs2_data_i,
    input logic [XLEN-1:0]       imm_i,
    input logic [ADDR_LEN-1:0]   pc_i,
    input logic [REG_ADDR_W-1:0] rd_addr_i,
    input logic                  rf_w_en_i,
    input logic                  mem_w_en_i,
    input wbsel_e                wbsel_i,
    input logic [XLEN-1:0]       wb_data_i,
    input logic [REG_ADDR_W-1:0] wb_rd_addr_i,
    input logic                  wb_rf_w_en_i
);

    int unsigned fail_count = 0;

    logic [XLEN-1:0]       shadow_mem   [DMEM_DEPTH];
    logic                  shadow_known [DMEM_DEPTH] = '{default: 1'b0};
    logic [XLEN-1:0]       op1;
    logic [XLEN-1:0]       op2;
    logic [DMEM_IDX_W-1:0] h1_idx;

    // h1 holds the item one edge old and h2 the one the wb outputs should show.
    logic                  h1_valid = 1'b0;
    logic [XLEN-1:0]       h1_result;
    logic [XLEN-1:0]       h1_rs2;
    logic [ADDR_LEN-1:0]   h1_pc;
    logic [REG_ADDR_W-1:0] h1_rd;
    logic                  h1_rf_w_en;
    logic                  h1_mem_w_en;
    logic [1:0]            h1_wbsel;
    logic                  h2_valid = 1'b0;
    logic [XLEN-1:0]       h2_data;
    logic                  h2_data_known;
    logic [REG_ADDR_W-1:0] h2_rd;
    logic                  h2_rf_w_en;
    logic [1:0]            h2_wbsel;

    function automatic logic [XLEN-1:0] alu_model(input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b,
                                                  input logic [3:0]      fn);
        logic [4:0] sh;
        logic       lt;
        sh = b[4:0];
        // differing signs decide the signed order, else the magnitudes do.
        lt = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : (a < b);
        if (fn == ALU_ADD)  return a + b;
        if (fn == ALU_SUB)  return a + ~b + 1;
        if (fn == ALU_SLL)  return a << sh;
        if (fn == ALU_SLT)  return XLEN'(lt);
        if (fn == ALU_SLTU) return XLEN'(a < b);
        if (fn == ALU_XOR)  return a ^ b;
        if (fn == ALU_SRL)  return a >> sh;
        if (fn == ALU_SRA)  return (a >> sh) | (a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0);
        if (fn == ALU_OR)   return a | b;
        if (fn == ALU_AND)  return a & b;
        return '0;
    endfunction

    assign op1    = (opsel1_i == OPSEL_RS1) ? rs1_data_i : (opsel1_i == OPSEL_PC) ? pc_i : '0;
    assign op2    = (opsel2_i == OPSEL_RS2) ? rs2_data_i : (opsel2_i == OPSEL_IMM) ? imm_i : '0;
    assign h1_idx = h1_result[DMEM_IDX_W+1:2];

    always_ff @(posedge clk_i) begin
        h1_valid    <= !reset_i;
        h1_result   <= alu_model(op1, op2, alu_func_i);
        h1_rs2      <= rs2_data_i;
        h1_pc       <= pc_i;
        h1_rd       <= rd_addr_i;
        h1_rf_w_en  <= rf_w_en_i;
        h1_mem_w_en <= mem_w_en_i;
        h1_wbsel    <= wbsel_i;
        h2_valid    <= h1_valid && !reset_i;
        h2_rd       <= h1_rd;
        h2_rf_w_en  <= h1_rf_w_en;
        h2_wbsel    <= h1_wbsel;
        // a load reads the memory as left by all older stores.
        if (h1_wbsel == 2'd0) h2_data <= h1_result;
        else if (h1_wbsel == 2'd1) h2_data <= shadow_mem[h1_idx];
        else if (h1_wbsel == 2'd2) h2_data <= h1_pc + 4;
        else h2_data <= '0;
        h2_data_known <= (h1_wbsel != 2'd1) || shadow_known[h1_idx];
        if (h1_valid && h1_mem_w_en) begin
            shadow_mem[h1_idx]   <= h1_rs2;
            shadow_known[h1_idx] <= 1'b1;
        end
    end

    a_reset_clears: assert property (@(posedge clk_i) disable iff (reset_i)
        !h2_valid |-> !wb_rf_w_en_i)
        else begin
            fail_count++;
            $error("ERROR reset_clears: expected rf_w_en 0, actual %b", $sampled(wb_rf_w_en_i));
        end

    a_wb_ctrl: assert property (@(posedge clk_i)
        h2_valid |-> (wb_rd_addr_i == h2_rd && wb_rf_w_en_i == h2_rf_w_en))
        else begin
            fail_count++;
            $error("ERROR wb_ctrl: expected rd %0d en %b, actual rd %0d en %b",
                   $sampled(h2_rd), $sampled(h2_rf_w_en), $sampled(wb_rd_addr_i),
                   $sampled(wb_rf_w_en_i));
        end

    a_alu_wb: assert property (@(posedge clk_i)
        h2_valid && h2_wbsel == WB_ALU |-> wb_data_i == h2_data)
        else begin
            fail_count++;
            $error("ERROR alu_wb: expected %h, actual %h", $sampled(h2_data),
                   $sampled(wb_data_i));
        end

    a_load_wb: assert property (@(posedge clk_i)
        h2_valid && h2_wbsel == WB_MEM && h2_data_known |-> wb_data_i == h2_data)
        else begin
            fail_count++;
            $error("ERROR load_wb: expected %h, actual %h", $sampled(h2_data),
                   $sampled(wb_data_i));
        end

    a_pc4_wb: assert property (@(posedge clk_i)
        h2_valid && h2_wbsel[1] |-> wb_data_i == h2_data)
        else begin
            fail_count++;
            $error("ERROR pc4_or_zero_wb: expected %h, actual %h", $sampled(h2_data),
                   $sampled(wb_data_i));
        end

endmodule

// ==== dv/ex_mem_tb.sv ====
// testbench for ex_mem_top; inputs change on the falling clock edge.
// writeback values are checked by the bound assertions, directed loads here too.
`timescale 1ns/1ps

module ex_mem_tb import core_pkg::*; ();

    logic                  clk;
    logic                  reset;
    opsel1_e               opsel1;
    opsel2_e               opsel2;
    alu_func_e             alu_func;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       imm;
    logic [ADDR_LEN-1:0]   pc;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic                  rf_w_en;
    logic                  mem_w_en;
    wbsel_e                wbsel;
    logic [XLEN-1:0]       wb_data;
    logic [REG_ADDR_W-1:0] wb_rd_addr;
    logic                  wb_rf_w_en;

    int seed          = 85;
    int err_count     = 0;
    int timeout_count = 0;

    tb_clock_gen u_clock_gen (.clk_o(clk), .reset_o(reset));

    ex_mem_top u_ex_mem_top (
        .clk(clk), .reset(reset), .opsel1_i(opsel1), .opsel2_i(opsel2),
        .alu_func_i(alu_func), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .imm_i(imm), .pc_i(pc), .rd_addr_i(rd_addr), .rf_w_en_i(rf_w_en),
        .mem_w_en_i(mem_w_en), .wbsel_i(wbsel), .wb_data_o(wb_data),
        .wb_rd_addr_o(wb_rd_addr), .wb_rf_w_en_o(wb_rf_w_en)
    );

    bind ex_mem_top ex_mem_assertions u_assertions (
        .clk_i(clk), .reset_i(reset), .opsel1_i(opsel1_i), .opsel2_i(opsel2_i),
        .alu_func_i(alu_func_i), .rs1_data_i(rs1_data_i), .rs2_data_i(rs2_data_i),
        .imm_i(imm_i), .pc_i(pc_i), .rd_addr_i(rd_addr_i), .rf_w_en_i(rf_w_en_i),
        .mem_w_en_i(mem_w_en_i), .wbsel_i(wbsel_i), .wb_data_i(wb_data_o),
        .wb_rd_addr_i(wb_rd_addr_o), .wb_rf_w_en_i(wb_rf_w_en_o)
    );

    task automatic drive_instr(input opsel1_e s1, input opsel2_e s2, input alu_func_e fn,
                               input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                               input logic [XLEN-1:0] im, input logic [ADDR_LEN-1:0] p,
                               input logic [REG_ADDR_W-1:0] rd, input logic rf_we,
                               input logic mem_we, input wbsel_e wb);
        @(negedge clk);
        opsel1   = s1;
        opsel2   = s2;
        alu_func = fn;
        rs1_data = a;
        rs2_data = b;
        imm      = im;
        pc       = p;
        rd_addr  = rd;
        rf_w_en  = rf_we;
        mem_w_en = mem_we;
        wbsel    = wb;
    endtask

    task automatic drive_idle();
        @(negedge clk);
        rf_w_en  = 1'b0;
        mem_w_en = 1'b0;
        wbsel    = WB_ALU;
    endtask

    task automatic store_word(input logic [XLEN-1:0] base, input logic [XLEN-1:0] offset,
                              input logic [XLEN-1:0] data);
        drive_instr(OPSEL_RS1, OPSEL_IMM, ALU_ADD, base, data, offset, '0, '0, 1'b0, 1'b1,
                    WB_ALU);
    endtask

    task automatic load_word(input logic [XLEN-1:0] base, input logic [XLEN-1:0] offset,
                             input logic [REG_ADDR_W-1:0] rd);
        drive_instr(OPSEL_RS1, OPSEL_IMM, ALU_ADD, base, '0, offset, '0, rd, 1'b1, 1'b0,
                    WB_MEM);
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (reset) begin
            timeout_count++;
            $display("reset still asserted after 20 cycles");
        end
    endtask

    // idles the inputs until the load with destination rd reaches writeback.
    task automatic check_load(input string name, input logic [REG_ADDR_W-1:0] rd,
                              input logic [XLEN-1:0] expected);
        int cycles;
        cycles = 0;
        do begin
            drive_idle();
            cycles++;
        end while (!(wb_rf_w_en && wb_rd_addr == rd) && cycles < 8);
        if (!(wb_rf_w_en && wb_rd_addr == rd)) begin
            timeout_count++;
            $display("load %s did not reach writeback within 8 cycles", name);
        end else if (wb_data !== expected) begin
            err_count++;
            $display("ERROR %s: expected %h, actual %h", name, expected, wb_data);
        end
    endtask

    initial begin
        // an enabled write held during reset must not come out.
        opsel1 = OPSEL_RS1;
        opsel2 = OPSEL_RS2;
        alu_func = ALU_ADD;
        rs1_data = 32'h1234_5678;
        rs2_data = 32'h0000_0001;
        imm = '0;
        pc = '0;
        rd_addr = 5'd7;
        rf_w_en = 1'b1;
        mem_w_en = 1'b0;
        wbsel = WB_ALU;
        wait_reset_release();

        // every function code, the six unused ones included.
        for (int f = 0; f < 16; f++) begin
            for (int k = 0; k < 4; k++) begin
                drive_instr(OPSEL_RS1, OPSEL_RS2, alu_func_e'(4'(f)), $random(seed),
                            $random(seed), $random(seed), $random(seed), REG_ADDR_W'(f + 1),
                            1'b1, 1'b0, WB_ALU);
            end
        end
        drive_instr(OPSEL_RS1, OPSEL_RS2, ALU_SRA, 32'h8000_0000, 32'd31, '0, '0, 5'd2,
                    1'b1, 1'b0, WB_ALU);
        drive_instr(OPSEL_RS1, OPSEL_RS2, ALU_SLT, 32'hFFFF_FFFF, 32'd1, '0, '0, 5'd3,
                    1'b1, 1'b0, WB_ALU);
        drive_instr(OPSEL_RS1, OPSEL_RS2, ALU_SLTU, 32'hFFFF_FFFF, 32'd1, '0, '0, 5'd4,
                    1'b1, 1'b0, WB_ALU);

        wait_reset_release();
        for (int k = 0; k < 4; k++) begin
            drive_instr(opsel1_e'(2'(k)), opsel2_e'(2'(3 - k)), ALU_ADD, $random(seed),
                        $random(seed), $random(seed), $random(seed), 5'd20, 1'b1, 1'b0,
                        WB_ALU);
        end
        drive_instr(OPSEL_PC, OPSEL_IMM, ALU_ADD, $random(seed), $random(seed),
                    32'h0000_0ff0, 32'h0000_1000, 5'd21, 1'b1, 1'b0, WB_ALU);

        wait_reset_release();
        store_word(32'h0000_0100, 32'h0000_0010, 32'hA5A5_0001);
        store_word(32'h0000_0100, 32'h0000_0020, 32'h5A5A_0002);
        load_word(32'h0000_0100, 32'h0000_0020, 5'd10);
        check_load("load_after_store", 5'd10, 32'h5A5A_0002);
        load_word(32'h0000_0100, 32'h0000_0010, 5'd11);
        check_load("older_word", 5'd11, 32'hA5A5_0001);
        store_word(32'h0000_0100, 32'h0000_0020, 32'hC0DE_0003);
        load_word(32'h0000_0100, 32'h0000_0010, 5'd12);
        check_load("neighbor_kept", 5'd12, 32'hA5A5_0001);
        load_word(32'h0000_0100, 32'h0000_0020, 5'd13);
        check_load("overwritten_word", 5'd13, 32'hC0DE_0003);
        store_word(32'h0000_0200, 32'hFFFF_FFFC, 32'h7777_0004);
        load_word(32'h0000_00FC, 32'h0000_0000, 5'd14);
        check_load("negative_offset", 5'd14, 32'h7777_0004);

        wait_reset_release();
        for (int k = 0; k < 4; k++) begin
            drive_instr(OPSEL_RS1, OPSEL_RS2, ALU_ADD, $random(seed), $random(seed),
                        $random(seed), $random(seed), 5'd22, 1'b1, 1'b0, WB_PC4);
        end
        drive_instr(OPSEL_RS1, OPSEL_RS2, ALU_OR, 32'h1, 32'h2, '0, 32'hFFFF_FFFC, 5'd23,
                    1'b1, 1'b0, WB_PC4);
        drive_instr(OPSEL_RS1, OPSEL_RS2, ALU_OR, 32'h1, 32'h2, '0, 32'h40, 5'd24,
                    1'b1, 1'b0, wbsel_e'(2'd3));

        // random mix, stores kept to a quarter of the slots.
        wait_reset_release();
        for (int k = 0; k < 200; k++) begin
            drive_instr(opsel1_e'(2'($random(seed))), opsel2_e'(2'($random(seed))),
                        alu_func_e'(4'($random(seed))), $random(seed), $random(seed),
                        $random(seed), $random(seed), REG_ADDR_W'($random(seed)),
                        1'($random(seed)), 2'($random(seed)) == 2'd0,
                        wbsel_e'(2'($random(seed))));
        end
        repeat (4) drive_idle();

        $display("summary: %0d value errors, %0d assertion failures, %0d timeouts",
                 err_count, u_ex_mem_top.u_assertions.fail_count, timeout_count);
        if (err_count == 0 && timeout_count == 0 &&
            u_ex_mem_top.u_assertions.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
logic/core_pkg.sv
logic/alu.sv
logic/execute.sv
logic/mem_stage.sv
logic/ex_mem_top.sv
dv/tb_clock_gen.sv
dv/ex_mem_assertions.sv
dv/ex_mem_tb.sv

// ==== Makefile ====
# Verilator flow for the EX/MEM back end.
# Run from the project root; every variable can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= ex_mem_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= all tests passed

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# the exit status is that of the search for the pass line.
sim: build
	@out="$$($(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
